/* overworldPkg.sv */
`default_nettype none

package overworldPkg;

	typedef enum logic [1:0] {
		modeTitle,
		modeOverworld,
		modeGym
	} gameModeT;

	// Same codes as the direction input
	typedef enum logic [1:0] {
		faceUp,
		faceRight,
		faceDown,
		faceLeft
	} facingT;

	// Upper two bits hold the facing, lower two the pose
	typedef enum logic [3:0] {
		upRest1, upStride1, upRest2, upStride2,
		rightRest1, rightStride1, rightRest2, rightStride2,
		downRest1, downStride1, downRest2, downStride2,
		leftRest1, leftStride1, leftRest2, leftStride2
	} walkStateT;

	typedef enum logic [1:0] {
		layerBlack,
		layerSprite,
		layerMap,
		layerTitle
	} layerT;

	localparam int coordW = 11;
	localparam int camW = 13;
	localparam int spriteAddrW = 13;
	localparam int mapAddrW = 19;

	// Sprite box on screen and sheet layout
	localparam int spriteX0 = 311;
	localparam int spriteY0 = 340;
	localparam int spriteW = 19;
	localparam int spriteH = 29;
	localparam int sheetW = 228;

	localparam int mapScale = 4;
	localparam int mapCols = 320;
	localparam int mapRows = 240;

	localparam int titleTop = 80;
	localparam int titleBottom = 370;
	localparam int titleRowScale = 3;
	localparam int titleCols = 200;
	localparam int titleColNum = 10;
	localparam int titleColDen = 32;

	localparam logic [7:0] startKey = 8'h2c;
	localparam int stepPeriod = 8;
	localparam int stepCountW = $clog2(stepPeriod);

	localparam int camUpMin = -340;
	localparam int camDownMax = 594;
	localparam int camRightMax = 951;
	localparam int camLeftMin = -311;

	// Character position limits for door and gym exit
	localparam int doorXMin = 411;
	localparam int doorXMax = 440;
	localparam int doorY = 420;
	localparam int exitY = 350;

	localparam int owSpawnX = 100;
	localparam int owSpawnY = 100;
	localparam int gymSpawnX = 0;
	localparam int gymSpawnY = 0;

	// Sheet column of each walk state, indexed by walkStateT
	localparam logic [7:0] frameOffset [16] = '{
		8'd133, 8'd114, 8'd133, 8'd152,
		8'd190, 8'd171, 8'd190, 8'd209,
		8'd19, 8'd0, 8'd19, 8'd38,
		8'd76, 8'd57, 8'd76, 8'd95
	};

endpackage

`default_nettype wire

/* pixelTapIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface pixelTapIf;
	import overworldPkg::*;

	logic visible;
	logic spriteHit;
	logic mapInside;
	logic titleBand;
	gameModeT mode;

	modport source (
		output visible,
		output spriteHit,
		output mapInside,
		output titleBand,
		output mode
	);

	modport sink (
		input visible,
		input spriteHit,
		input mapInside,
		input titleBand,
		input mode
	);

endinterface

`default_nettype wire

/* gameModeFsm.sv */
`timescale 1ns/10ps
`default_nettype none

module gameModeFsm (
	input logic Clk,
	input logic rstN,
	input logic frameStart,
	input logic [7:0] keycode,
	input logic signed [overworldPkg::camW-1:0] camX,
	input logic signed [overworldPkg::camW-1:0] camY,
	output overworldPkg::gameModeT mode,
	output logic warp,
	output logic warpToGym
);
	import overworldPkg::*;

	logic signed [camW:0] charX;
	logic signed [camW:0] charY;
	logic atDoor;
	logic atExit;
	gameModeT nextMode;

	// Character sits at a fixed screen spot
	assign charX = camX + (camW + 1)'(spriteX0);
	assign charY = camY + (camW + 1)'(spriteY0);

	assign atDoor = (charX > doorXMin) && (charX < doorXMax) && (charY == doorY);
	assign atExit = (charY == exitY);

	always_comb begin
		nextMode = mode;
		warp = 1'b0;
		warpToGym = 1'b0;
		if (frameStart) begin
			case (mode)
				modeTitle: begin
					if (keycode == startKey) begin
						nextMode = modeOverworld;
						warp = 1'b1;
					end
				end
				modeOverworld: begin
					if (atDoor) begin
						nextMode = modeGym;
						warp = 1'b1;
						warpToGym = 1'b1;
					end
				end
				modeGym: begin
					if (atExit) begin
						nextMode = modeOverworld;
						warp = 1'b1;
					end
				end
				default: nextMode = modeTitle;
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			mode <= modeTitle;
		end else begin
			mode <= nextMode;
		end
	end

endmodule

`default_nettype wire

/* walkAnimator.sv */
`timescale 1ns/10ps
`default_nettype none

module walkAnimator (
	input logic Clk,
	input logic rstN,
	input logic frameStart,
	input logic moving,
	input logic warp,
	input overworldPkg::facingT direction,
	input overworldPkg::gameModeT mode,
	output overworldPkg::walkStateT walkState,
	output logic stepReq
);
	import overworldPkg::*;

	facingT facing;
	logic [1:0] pose;
	logic [1:0] nextPose;
	logic [stepCountW-1:0] stepCount;
	logic inPlay;

	assign facing = facingT'(walkState[3:2]);
	assign pose = walkState[1:0];
	// rest1, stride1, rest2, stride2, then wrap
	assign nextPose = pose + 2'd1;

	assign inPlay = (mode == modeOverworld) || (mode == modeGym);
	assign stepReq = inPlay && moving && (direction == facing);

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			walkState <= downRest1;
			stepCount <= '0;
		end else if (frameStart) begin
			if (warp) begin
				walkState <= downRest1;
				stepCount <= '0;
			end else if (inPlay) begin
				if (!moving) begin
					walkState <= walkStateT'({facing, 2'd0});
				end else if (direction != facing) begin
					// Turning only, no step taken
					walkState <= walkStateT'({direction, 2'd0});
				end else begin
					if (stepCount == '0) begin
						walkState <= walkStateT'({facing, nextPose});
					end
					if (stepCount == stepCountW'(stepPeriod - 1)) begin
						stepCount <= '0;
					end else begin
						stepCount <= stepCount + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* cameraTracker.sv */
`timescale 1ns/10ps
`default_nettype none

module cameraTracker (
	input logic Clk,
	input logic rstN,
	input logic frameStart,
	input logic stepReq,
	input logic warp,
	input logic warpToGym,
	input overworldPkg::facingT direction,
	input logic [3:0] collisionBits,
	output logic signed [overworldPkg::camW-1:0] camX,
	output logic signed [overworldPkg::camW-1:0] camY,
	output logic [overworldPkg::mapAddrW-1:0] collisionAddr
);
	import overworldPkg::*;

	logic canMove;
	logic signed [camW:0] charX;
	logic signed [camW:0] charY;

	// Bit 3 up, bit 0 right, bit 1 down, bit 2 left
	always_comb begin
		case (direction)
			faceUp: canMove = (camY > camUpMin) && !collisionBits[3];
			faceRight: canMove = (camX <= camRightMax) && !collisionBits[0];
			faceDown: canMove = (camY <= camDownMax) && !collisionBits[1];
			default: canMove = (camX > camLeftMin) && !collisionBits[2];
		endcase
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			camX <= '0;
			camY <= '0;
		end else if (frameStart) begin
			if (warp) begin
				camX <= warpToGym ? camW'(gymSpawnX) : camW'(owSpawnX);
				camY <= warpToGym ? camW'(gymSpawnY) : camW'(owSpawnY);
			end else if (stepReq && canMove) begin
				case (direction)
					faceUp: camY <= camY - camW'(1);
					faceRight: camX <= camX + camW'(1);
					faceDown: camY <= camY + camW'(1);
					default: camX <= camX - camW'(1);
				endcase
			end
		end
	end

	assign charX = camX + (camW + 1)'(spriteX0);
	assign charY = camY + (camW + 1)'(spriteY0);

	// Bounds keep the character position non-negative
	assign collisionAddr = mapAddrW'((charY / mapScale) * mapCols + charX / mapScale);

endmodule

`default_nettype wire

/* pixelFetch.sv */
`timescale 1ns/10ps
`default_nettype none

module pixelFetch (
	input logic Clk,
	input logic rstN,
	input logic [overworldPkg::coordW-1:0] drawX,
	input logic [overworldPkg::coordW-1:0] drawY,
	input logic displayEnable,
	input logic signed [overworldPkg::camW-1:0] camX,
	input logic signed [overworldPkg::camW-1:0] camY,
	input overworldPkg::walkStateT walkState,
	input overworldPkg::gameModeT mode,
	output logic [overworldPkg::spriteAddrW-1:0] spriteAddr,
	output logic [overworldPkg::mapAddrW-1:0] mapAddr,
	output logic [overworldPkg::mapAddrW-1:0] titleAddr,
	pixelTapIf.source tap
);
	import overworldPkg::*;

	logic inSprite;
	logic [coordW-1:0] spriteRow;
	logic [coordW-1:0] spriteCol;
	logic signed [camW:0] worldX;
	logic signed [camW:0] worldY;
	logic worldNeg;
	logic inMap;
	logic [coordW-1:0] titleRow;
	logic inBand;

	assign inSprite = (drawX >= spriteX0) && (drawX < spriteX0 + spriteW) &&
		(drawY >= spriteY0) && (drawY < spriteY0 + spriteH);
	assign spriteRow = drawY - coordW'(spriteY0);
	assign spriteCol = drawX - coordW'(spriteX0);

	assign spriteAddr = inSprite ?
		spriteAddrW'(sheetW * spriteRow + spriteCol + frameOffset[walkState]) : '0;

	// Screen to world through the camera
	assign worldX = $signed({2'b00, drawX}) + camX;
	assign worldY = $signed({2'b00, drawY}) + camY;
	assign worldNeg = (worldX < 0) || (worldY < 0);

	assign mapAddr = worldNeg ? '0 :
		mapAddrW'((worldY / mapScale) * mapCols + worldX / mapScale);
	assign inMap = !worldNeg && (worldX / mapScale < mapCols) && (worldY / mapScale < mapRows);

	// Rows tripled, columns scaled by 10/32
	assign titleRow = drawY - coordW'(titleTop);
	assign titleAddr = mapAddrW'((titleRow / titleRowScale) * titleCols +
		(drawX * titleColNum) / titleColDen);
	assign inBand = (drawY >= titleTop) && (drawY <= titleBottom);

	// Lines up with the memory read data
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			tap.visible <= 1'b0;
			tap.spriteHit <= 1'b0;
			tap.mapInside <= 1'b0;
			tap.titleBand <= 1'b0;
			tap.mode <= modeTitle;
		end else begin
			tap.visible <= displayEnable;
			tap.spriteHit <= inSprite;
			tap.mapInside <= inMap;
			tap.titleBand <= inBand;
			tap.mode <= mode;
		end
	end

endmodule

`default_nettype wire

/* pixelCompose.sv */
`timescale 1ns/10ps
`default_nettype none

module pixelCompose (
	input logic Clk,
	input logic rstN,
	pixelTapIf.sink tap,
	input logic [3:0] spriteIndex,
	input logic [7:0] mapIndex,
	input logic [4:0] titleIndex,
	output overworldPkg::layerT pixelLayer,
	output logic [7:0] colorIndex
);
	import overworldPkg::*;

	layerT nextLayer;
	logic [7:0] nextIndex;

	always_comb begin
		nextLayer = layerBlack;
		case (tap.mode)
			modeOverworld, modeGym: begin
				if (tap.visible && tap.mapInside) begin
					// Index 0 is the transparent sprite colour
					if (tap.spriteHit && spriteIndex != 4'd0) begin
						nextLayer = layerSprite;
					end else if (tap.mode == modeOverworld) begin
						nextLayer = layerMap;
					end
				end
			end
			modeTitle: begin
				if (tap.visible && tap.titleBand) begin
					nextLayer = layerTitle;
				end
			end
			default: nextLayer = layerBlack;
		endcase

		case (nextLayer)
			layerSprite: nextIndex = {4'd0, spriteIndex};
			layerMap: nextIndex = mapIndex;
			layerTitle: nextIndex = {3'd0, titleIndex};
			default: nextIndex = 8'd0;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			pixelLayer <= layerBlack;
			colorIndex <= 8'd0;
		end else begin
			pixelLayer <= nextLayer;
			colorIndex <= nextIndex;
		end
	end

endmodule

`default_nettype wire

/* overworldRenderer.sv */
`timescale 1ns/10ps
`default_nettype none

module overworldRenderer (
	input logic Clk,
	input logic rstN,
	input logic frameStart,
	input logic [7:0] keycode,
	input logic moving,
	input logic [1:0] direction,
	input logic [overworldPkg::coordW-1:0] drawX,
	input logic [overworldPkg::coordW-1:0] drawY,
	input logic displayEnable,
	input logic [3:0] collisionBits,
	input logic [3:0] spriteIndex,
	input logic [7:0] mapIndex,
	input logic [4:0] titleIndex,
	output logic [overworldPkg::spriteAddrW-1:0] spriteAddr,
	output logic [overworldPkg::mapAddrW-1:0] mapAddr,
	output logic [overworldPkg::mapAddrW-1:0] titleAddr,
	output logic [overworldPkg::mapAddrW-1:0] collisionAddr,
	output overworldPkg::layerT pixelLayer,
	output logic [7:0] colorIndex
);
	import overworldPkg::*;

	facingT dirFacing;
	gameModeT mode;
	logic warp;
	logic warpToGym;
	logic signed [camW-1:0] camX;
	logic signed [camW-1:0] camY;
	walkStateT walkState;
	logic stepReq;

	pixelTapIf tap ();

	assign dirFacing = facingT'(direction);

	gameModeFsm i_gameModeFsm (
		.Clk(Clk),
		.rstN(rstN),
		.frameStart(frameStart),
		.keycode(keycode),
		.camX(camX),
		.camY(camY),
		.mode(mode),
		.warp(warp),
		.warpToGym(warpToGym)
	);

	walkAnimator i_walkAnimator (
		.Clk(Clk),
		.rstN(rstN),
		.frameStart(frameStart),
		.moving(moving),
		.warp(warp),
		.direction(dirFacing),
		.mode(mode),
		.walkState(walkState),
		.stepReq(stepReq)
	);

	cameraTracker i_cameraTracker (
		.Clk(Clk),
		.rstN(rstN),
		.frameStart(frameStart),
		.stepReq(stepReq),
		.warp(warp),
		.warpToGym(warpToGym),
		.direction(dirFacing),
		.collisionBits(collisionBits),
		.camX(camX),
		.camY(camY),
		.collisionAddr(collisionAddr)
	);

	pixelFetch i_pixelFetch (
		.Clk(Clk),
		.rstN(rstN),
		.drawX(drawX),
		.drawY(drawY),
		.displayEnable(displayEnable),
		.camX(camX),
		.camY(camY),
		.walkState(walkState),
		.mode(mode),
		.spriteAddr(spriteAddr),
		.mapAddr(mapAddr),
		.titleAddr(titleAddr),
		.tap(tap.source)
	);

	pixelCompose i_pixelCompose (
		.Clk(Clk),
		.rstN(rstN),
		.tap(tap.sink),
		.spriteIndex(spriteIndex),
		.mapIndex(mapIndex),
		.titleIndex(titleIndex),
		.pixelLayer(pixelLayer),
		.colorIndex(colorIndex)
	);

endmodule

`default_nettype wire

/* rendererTiming_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module rendererTiming_checker (
	input logic Clk,
	input logic rstN,
	input logic frameStart,
	input logic displayEnable,
	input overworldPkg::gameModeT mode,
	input overworldPkg::layerT pixelLayer
);
	import overworldPkg::*;

	// Two pipeline stages from input pixel to output layer
	blankIsBlack: assert property (@(posedge Clk) disable iff (!rstN)
		!$past(displayEnable, 2) |-> pixelLayer == layerBlack)
		else $error("pixelLayer not black two cycles after displayEnable low");

	modeOnFrame: assert property (@(posedge Clk) disable iff (!rstN)
		mode != $past(mode) |-> $past(frameStart))
		else $error("mode changed without a frameStart in the cycle before");

	noMapOnTitle: assert property (@(posedge Clk) disable iff (!rstN)
		mode == modeTitle |-> pixelLayer != layerMap)
		else $error("map layer shown in title mode");

endmodule

bind overworldRenderer rendererTiming_checker i_rendererTiming_checker (
	.Clk(Clk),
	.rstN(rstN),
	.frameStart(frameStart),
	.displayEnable(displayEnable),
	.mode(mode),
	.pixelLayer(pixelLayer)
);

`default_nettype wire

/* tbOverworldRenderer.sv */
`timescale 1ns/10ps
`default_nettype none

module tbOverworldRenderer;
	import overworldPkg::*;

	localparam int wideBurst = 60;
	localparam int walkBurst = 16;
	localparam int quickBurst = 2;
	// Twice the cycles of reset, test drains and all frames by burst size
	localparam int cycleLimit = 2 * (10 + 7 * 4 + 5 * (wideBurst + 1) +
		29 * (walkBurst + 1) + 347 * (quickBurst + 1));

	logic Clk = 1'b0;
	logic rstN;
	logic frameStart;
	logic [7:0] keycode;
	logic moving;
	logic [1:0] direction;
	logic [10:0] drawX;
	logic [10:0] drawY;
	logic displayEnable;
	logic [3:0] collisionBits;
	logic [3:0] spriteIndex;
	logic [7:0] mapIndex;
	logic [4:0] titleIndex;
	logic [12:0] spriteAddr;
	logic [18:0] mapAddr;
	logic [18:0] titleAddr;
	logic [18:0] collisionAddr;
	layerT pixelLayer;
	logic [7:0] colorIndex;

	int seed = 32'h29520844;
	// Model of mode, camera and walk state
	int modeM = 0;
	int camXM = 0;
	int camYM = 0;
	int faceM = 2;
	int poseM = 0;
	int countM = 0;
	int blockAddr = -1;
	logic [3:0] blockBits = 4'd0;

	int errCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int errorsAtStart;
	int checksAtStart;
	string testName;

	// Stage 0 is the pixel on the address inputs, stage 2 the one at the outputs
	logic chk0 = 1'b0;
	logic chk1 = 1'b0;
	logic chk2 = 1'b0;
	int expSprite;
	int expMap;
	int expTitle;
	int expColl;
	layerT expLayer [3];
	int expIndex [3];

	overworldRenderer i_overworldRenderer (.*);

	always #20 Clk = ~Clk;

	function automatic logic [3:0] spriteWord(input int a);
		// Every fifth word is transparent
		if (a % 5 == 0) return 4'd0;
		return 4'((a / 5 + a / 97) % 15 + 1);
	endfunction

	function automatic logic [7:0] mapWord(input int a);
		return 8'((a * 37) ^ (a >> 8) ^ (a >> 13));
	endfunction

	function automatic logic [4:0] titleWord(input int a);
		return 5'(a + (a >> 5) + (a >> 10) + (a >> 15));
	endfunction

	// One-cycle image memories and collision table
	always @(posedge Clk) begin
		spriteIndex <= spriteWord(spriteAddr);
		mapIndex <= mapWord(mapAddr);
		titleIndex <= titleWord(titleAddr);
		collisionBits <= (collisionAddr == blockAddr) ? blockBits : 4'd0;
	end

	function automatic int offsetRef(input int face, input int pose);
		int base;
		// Sheet order is down, left, up, right with stride1 first
		case (face)
			0: base = 114;
			1: base = 171;
			2: base = 0;
			default: base = 57;
		endcase
		case (pose)
			1: return base;
			3: return base + 38;
			default: return base + 19;
		endcase
	endfunction

	function automatic logic inBox(input int x, input int y);
		return x >= 311 && x < 330 && y >= 340 && y < 369;
	endfunction

	function automatic int spriteRef(input int x, input int y);
		if (!inBox(x, y)) return 0;
		return 228 * (y - 340) + (x - 311) + offsetRef(faceM, poseM);
	endfunction

	function automatic int mapRef(input int x, input int y);
		int wx;
		int wy;
		wx = x + camXM;
		wy = y + camYM;
		if (wx < 0 || wy < 0) return 0;
		return (wy / 4) * 320 + wx / 4;
	endfunction

	function automatic logic insideRef(input int x, input int y);
		int wx;
		int wy;
		wx = x + camXM;
		wy = y + camYM;
		return wx >= 0 && wy >= 0 && wx / 4 < 320 && wy / 4 < 240;
	endfunction

	function automatic int collRef();
		return ((camYM + 340) / 4) * 320 + (camXM + 311) / 4;
	endfunction

	task automatic stepModel(input logic [7:0] key, input logic mov, input int dir);
		logic warpNow;
		logic toGym;
		logic hit;
		warpNow = 1'b0;
		toGym = 1'b0;
		hit = (collRef() == blockAddr);
		if (modeM == 0 && key == 8'h2c) begin
			warpNow = 1'b1;
			modeM = 1;
		end else if (modeM == 1 && camXM + 311 > 411 && camXM + 311 < 440 &&
			camYM + 340 == 420) begin
			warpNow = 1'b1;
			toGym = 1'b1;
			modeM = 2;
		end else if (modeM == 2 && camYM + 340 == 350) begin
			warpNow = 1'b1;
			modeM = 1;
		end
		if (warpNow) begin
			camXM = toGym ? 0 : 100;
			camYM = toGym ? 0 : 100;
			faceM = 2;
			poseM = 0;
			countM = 0;
		end else if (modeM != 0) begin
			if (!mov) begin
				poseM = 0;
			end else if (dir != faceM) begin
				faceM = dir;
				poseM = 0;
			end else begin
				if (countM == 0) poseM = (poseM + 1) % 4;
				countM = (countM + 1) % 8;
				// Collision bits are 3 up, 0 right, 1 down, 2 left
				case (dir)
					0: if (camYM > -340 && !(hit && blockBits[3])) camYM = camYM - 1;
					1: if (camXM <= 951 && !(hit && blockBits[0])) camXM = camXM + 1;
					2: if (camYM <= 594 && !(hit && blockBits[1])) camYM = camYM + 1;
					default: if (camXM > -311 && !(hit && blockBits[2])) camXM = camXM - 1;
				endcase
			end
		end
	endtask

	task automatic drivePixel(input int x, input int y, input logic de);
		int sAddr;
		int tAddr;
		layerT lay;
		int idx;
		sAddr = spriteRef(x, y);
		tAddr = ((y - 80) / 3) * 200 + (x * 10) / 32;
		lay = layerBlack;
		idx = 0;
		if (modeM == 0) begin
			if (de && y >= 80 && y <= 370) begin
				lay = layerTitle;
				idx = titleWord(tAddr);
			end
		end else if (de && insideRef(x, y)) begin
			if (inBox(x, y) && spriteWord(sAddr) != 4'd0) begin
				lay = layerSprite;
				idx = spriteWord(sAddr);
			end else if (modeM == 1) begin
				lay = layerMap;
				idx = mapWord(mapRef(x, y));
			end
		end
		@(posedge Clk);
		frameStart <= 1'b0;
		drawX <= 11'(x);
		drawY <= 11'(y);
		displayEnable <= de;
		expSprite <= sAddr;
		expMap <= mapRef(x, y);
		expTitle <= (y >= 80 && y <= 370) ? tAddr : -1;
		expColl <= collRef();
		expLayer[0] <= lay;
		expIndex[0] <= idx;
		chk0 <= 1'b1;
	endtask

	// Half the pixels land on or near the sprite box
	task automatic pixelBurst(input int n);
		int x;
		int y;
		logic de;
		repeat (n) begin
			if ({$random(seed)} % 2 == 0) begin
				x = 305 + {$random(seed)} % 32;
				y = 335 + {$random(seed)} % 40;
			end else begin
				x = {$random(seed)} % 640;
				y = {$random(seed)} % 480;
			end
			de = ({$random(seed)} % 8) != 0;
			drivePixel(x, y, de);
		end
	endtask

	task automatic runFrame(input logic [7:0] key, input logic mov, input int dir, input int n);
		@(posedge Clk);
		frameStart <= 1'b1;
		keycode <= key;
		moving <= mov;
		direction <= 2'(dir);
		displayEnable <= 1'b0;
		chk0 <= 1'b0;
		stepModel(key, mov, dir);
		pixelBurst(n);
	endtask

	task automatic startTest(input string name);
		testName = name;
		errorsAtStart = errCount;
		checksAtStart = checkCount;
	endtask

	task automatic finishTest();
		@(posedge Clk);
		frameStart <= 1'b0;
		displayEnable <= 1'b0;
		chk0 <= 1'b0;
		repeat (3) @(posedge Clk);
		$display("%s: %0d checks, %0d errors", testName, checkCount - checksAtStart,
			errCount - errorsAtStart);
	endtask

	task automatic compareValue(input string what, input int expected, input int actual);
		checkCount++;
		if (actual != expected) begin
			errCount++;
			$display("** Error [%s] %s: expected %0d, actual %0d", testName, what,
				expected, actual);
		end
	endtask

	always @(posedge Clk) begin
		chk1 <= chk0;
		chk2 <= chk1;
		expLayer[1] <= expLayer[0];
		expLayer[2] <= expLayer[1];
		expIndex[1] <= expIndex[0];
		expIndex[2] <= expIndex[1];
	end

	// Outputs are stable at the falling edge
	always @(negedge Clk) begin
		if (chk0) begin
			compareValue("spriteAddr", expSprite, spriteAddr);
			compareValue("mapAddr", expMap, mapAddr);
			if (expTitle >= 0) compareValue("titleAddr", expTitle, titleAddr);
			compareValue("collisionAddr", expColl, collisionAddr);
		end
		if (chk2) begin
			compareValue("pixelLayer", expLayer[2], pixelLayer);
			compareValue("colorIndex", expIndex[2], colorIndex);
		end
	end

	always @(posedge Clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit) begin
			$display("Timeout after %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		rstN = 1'b0;
		frameStart = 1'b0;
		keycode = 8'd0;
		moving = 1'b0;
		direction = 2'd0;
		drawX = 11'd0;
		drawY = 11'd0;
		displayEnable = 1'b0;
		collisionBits = 4'd0;
		spriteIndex = 4'd0;
		mapIndex = 8'd0;
		titleIndex = 5'd0;
		repeat (10) @(posedge Clk);
		rstN <= 1'b1;

		startTest("titlePixels");
		runFrame(8'h00, 1'b0, 0, wideBurst);
		runFrame(8'h1d, 1'b1, 1, wideBurst);
		finishTest();

		startTest("startWarp");
		runFrame(8'h2c, 1'b0, 2, wideBurst);
		finishTest();

		startTest("walkRight");
		repeat (21) runFrame(8'h00, 1'b1, 1, walkBurst);
		runFrame(8'h00, 1'b1, 0, walkBurst);
		finishTest();

		startTest("collisionBlock");
		blockAddr <= collRef();
		blockBits <= 4'b1000;
		repeat (6) runFrame(8'h00, 1'b1, 0, walkBurst);
		finishTest();

		startTest("doorToGym");
		blockAddr <= -1;
		blockBits <= 4'd0;
		repeat (20) runFrame(8'h00, 1'b1, 0, quickBurst);
		runFrame(8'h00, 1'b0, 0, wideBurst);
		finishTest();

		startTest("boundStop");
		repeat (316) runFrame(8'h00, 1'b1, 3, quickBurst);
		runFrame(8'h00, 1'b1, 3, walkBurst);
		finishTest();

		startTest("gymExit");
		repeat (11) runFrame(8'h00, 1'b1, 2, quickBurst);
		runFrame(8'h00, 1'b0, 2, wideBurst);
		finishTest();

		$display("Total: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0 && checkCount > 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
overworldPkg.sv
pixelTapIf.sv
gameModeFsm.sv
walkAnimator.sv
cameraTracker.sv
pixelFetch.sv
pixelCompose.sv
overworldRenderer.sv
rendererTiming_checker.sv
tbOverworldRenderer.sv

/* Makefile */
TOP := tbOverworldRenderer

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o simv
	./obj_dir/simv > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	cat sim.log
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
